// ==== common/display_cmd_pkg.sv ====
// Op codes, widths and bundles for the command front end; pixel color holds an index or a value
package display_cmd_pkg;

    localparam int COORD_W       = 10;
    localparam int COLOR_W       = 10;
    localparam int INDEX_W       = 4;
    localparam int PALETTE_DEPTH = 16;
    // Operand counter saturates at its maximum
    localparam int COUNT_W       = 16;

    // Command op codes, the first byte of each frame
    typedef enum logic [7:0] {
        CLEAR_BUFFER = 8'h10,
        ASSIGN_COLOR = 8'h11,
        DRAW_SPRITE  = 8'h12,
        SHOW_BUFFER  = 8'h14
    } op_code_e;

    // Framed SPI command stream
    typedef struct packed {
        op_code_e               op_code;
        logic                   op_code_valid;
        logic [7:0]             operand;
        logic                   operand_valid;
        logic [COUNT_W-1:0]     operand_count;
    } spi_command_t;

    // Palette write request
    typedef struct packed {
        logic [INDEX_W-1:0]     index;
        logic [COLOR_W-1:0]     value;
        logic                   enable;
    } color_assign_t;

    // Sprite setup, stable once operand 8 has arrived
    typedef struct packed {
        logic [COORD_W-1:0]     x;
        logic [COORD_W-1:0]     y;
        logic [COORD_W-1:0]     width;
        logic [4:0]             total_colors;
        logic [INDEX_W-1:0]     palette_offset;
    } sprite_setup_t;

    // Palette index in the low bits before the palette, 10-bit color value after it
    typedef struct packed {
        logic [COORD_W-1:0]     x;
        logic [COORD_W-1:0]     y;
        logic [COLOR_W-1:0]     color;
    } pixel_t;

endpackage

// ==== spi/spi_byte_receiver.sv ====
// SPI mode 0 slave, MSB first; SCK must stay below a quarter of clock_in, no MISO
`timescale 1ns/10ps

module spi_byte_receiver (
    input  logic       clock_in,
    input  logic       rst_n,
    input  logic       spi_sck,
    input  logic       spi_cs_n,
    input  logic       spi_mosi,
    output logic [7:0] byte_data,
    output logic       byte_strobe,
    output logic       frame_start,
    output logic       frame_active
);

    logic [1:0] sck_sync;
    logic [1:0] cs_sync;
    logic [1:0] mosi_sync;
    logic       sck_prev;
    logic       cs_prev;
    logic       sck_rise;
    logic [2:0] bit_count;
    logic [6:0] shift_reg;

    // Edges seen after the two-flop synchronizers
    assign sck_rise     = sck_sync[1] & ~sck_prev;
    assign frame_start  = cs_prev & ~cs_sync[1];
    assign frame_active = ~cs_sync[1];

    always_ff @(posedge clock_in or negedge rst_n) begin
        if (!rst_n) begin
            sck_sync    <= '0;
            cs_sync     <= '1;
            mosi_sync   <= '0;
            sck_prev    <= 1'b0;
            cs_prev     <= 1'b1;
            bit_count   <= '0;
            shift_reg   <= '0;
            byte_strobe <= 1'b0;
        end else begin
            sck_sync    <= {sck_sync[0], spi_sck};
            cs_sync     <= {cs_sync[0], spi_cs_n};
            mosi_sync   <= {mosi_sync[0], spi_mosi};
            sck_prev    <= sck_sync[1];
            cs_prev     <= cs_sync[1];
            byte_strobe <= 1'b0;
            if (cs_sync[1]) begin
                // Partial byte is dropped while deselected
                bit_count <= '0;
                shift_reg <= '0;
            end else if (sck_rise) begin
                bit_count <= bit_count + 3'd1;
                shift_reg <= {shift_reg[5:0], mosi_sync[1]};
                if (bit_count == 3'd7) begin
                    byte_strobe <= 1'b1;
                end
            end
        end
    end

    // Completed byte, valid with byte_strobe
    always_ff @(posedge clock_in) begin
        if (sck_rise && !cs_sync[1] && bit_count == 3'd7) begin
            byte_data <= {shift_reg, mosi_sync[1]};
        end
    end

endmodule

// ==== spi/command_framer.sv ====
// First byte of a frame is the op code; operand count saturates, all state clears on CS rise
`timescale 1ns/10ps

module command_framer (
    input  logic                        clock_in,
    input  logic                        rst_n,
    input  logic [7:0]                  byte_data,
    input  logic                        byte_strobe,
    input  logic                        frame_start,
    input  logic                        frame_active,
    output display_cmd_pkg::spi_command_t command
);

    import display_cmd_pkg::*;

    op_code_e           op_code_q;
    logic               op_valid_q;
    logic [7:0]         operand_q;
    logic               operand_valid_q;
    logic [COUNT_W-1:0] count_q;

    always_ff @(posedge clock_in or negedge rst_n) begin
        if (!rst_n) begin
            op_valid_q      <= 1'b0;
            operand_valid_q <= 1'b0;
            count_q         <= '0;
        end else begin
            operand_valid_q <= 1'b0;
            if (!frame_active || frame_start) begin
                op_valid_q <= 1'b0;
                count_q    <= '0;
            end else if (byte_strobe) begin
                if (!op_valid_q) begin
                    op_valid_q <= 1'b1;
                end else begin
                    operand_valid_q <= 1'b1;
                    if (count_q != {COUNT_W{1'b1}}) begin
                        count_q <= count_q + COUNT_W'(1);
                    end
                end
            end
        end
    end

    always_ff @(posedge clock_in) begin
        if (frame_active && byte_strobe) begin
            if (!op_valid_q) begin
                op_code_q <= op_code_e'(byte_data);
            end else begin
                operand_q <= byte_data;
            end
        end
    end

    assign command = '{op_code: op_code_q, op_code_valid: op_valid_q, operand: operand_q,
                       operand_valid: operand_valid_q, operand_count: count_q};

    // An operand only ever belongs to an open command
    operand_needs_op_code: assert property (@(posedge clock_in) disable iff (!rst_n)
        command.operand_valid |-> command.op_code_valid);

endmodule

// ==== rtl/command_decoder.sv ====
// Decodes four op codes; unknown op codes are ignored and setup registers hold stale values
`timescale 1ns/10ps

module command_decoder (
    input  logic                          clock_in,
    input  logic                          rst_n,
    input  display_cmd_pkg::spi_command_t  command,
    output display_cmd_pkg::color_assign_t color_assign,
    output display_cmd_pkg::sprite_setup_t sprite_setup,
    output logic                          sprite_enable,
    output logic                          sprite_data_strobe,
    output logic [7:0]                    sprite_data,
    output logic                          clear_buffer,
    output logic                          show_buffer
);

    import display_cmd_pkg::*;

    logic               color_enable;
    logic [INDEX_W-1:0] color_index;
    logic [COLOR_W-1:0] color_value;
    logic [COORD_W-1:0] sprite_x;
    logic [COORD_W-1:0] sprite_y;
    logic [COORD_W-1:0] sprite_width;
    logic [4:0]         total_colors;
    logic [INDEX_W-1:0] palette_offset;
    logic               operand_in;

    assign operand_in = command.op_code_valid && command.operand_valid;

    // Flags follow the open command and drop as soon as it closes
    always_ff @(posedge clock_in or negedge rst_n) begin
        if (!rst_n) begin
            clear_buffer       <= 1'b0;
            show_buffer        <= 1'b0;
            color_enable       <= 1'b0;
            sprite_enable      <= 1'b0;
            sprite_data_strobe <= 1'b0;
        end else if (!command.op_code_valid) begin
            clear_buffer       <= 1'b0;
            show_buffer        <= 1'b0;
            color_enable       <= 1'b0;
            sprite_enable      <= 1'b0;
            sprite_data_strobe <= 1'b0;
        end else begin
            color_enable       <= 1'b0;
            sprite_data_strobe <= 1'b0;
            case (command.op_code)
                CLEAR_BUFFER: clear_buffer <= 1'b1;
                SHOW_BUFFER:  show_buffer <= 1'b1;
                ASSIGN_COLOR: color_enable <= operand_in && command.operand_count == COUNT_W'(4);
                DRAW_SPRITE: begin
                    // Operands from the ninth on are sprite data
                    if (operand_in && command.operand_count > COUNT_W'(8)) begin
                        sprite_enable      <= 1'b1;
                        sprite_data_strobe <= 1'b1;
                    end
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clock_in) begin
        if (operand_in) begin
            case (command.op_code)
                ASSIGN_COLOR: begin
                    case (command.operand_count)
                        COUNT_W'(1): color_index <= command.operand[3:0];
                        COUNT_W'(2): color_value[9:6] <= command.operand[7:4];
                        COUNT_W'(3): color_value[5:3] <= command.operand[7:5];
                        COUNT_W'(4): color_value[2:0] <= command.operand[7:5];
                        default: ;
                    endcase
                end
                DRAW_SPRITE: begin
                    // Coordinates and width arrive high byte first, 2 bits used
                    case (command.operand_count)
                        COUNT_W'(1): sprite_x <= {command.operand[1:0], 8'h00};
                        COUNT_W'(2): sprite_x[7:0] <= command.operand;
                        COUNT_W'(3): sprite_y <= {command.operand[1:0], 8'h00};
                        COUNT_W'(4): sprite_y[7:0] <= command.operand;
                        COUNT_W'(5): sprite_width <= {command.operand[1:0], 8'h00};
                        COUNT_W'(6): sprite_width[7:0] <= command.operand;
                        COUNT_W'(7): total_colors <= command.operand[4:0];
                        COUNT_W'(8): palette_offset <= command.operand[3:0];
                        default: sprite_data <= command.operand;
                    endcase
                end
                default: ;
            endcase
        end
    end

    assign color_assign = '{index: color_index, value: color_value, enable: color_enable};
    assign sprite_setup = '{x: sprite_x, y: sprite_y, width: sprite_width,
                            total_colors: total_colors, palette_offset: palette_offset};

    // Palette write is one pulse per assign-color command
    color_enable_pulse: assert property (@(posedge clock_in) disable iff (!rst_n)
        color_assign.enable |=> !color_assign.enable);

endmodule

// ==== rtl/palette_store.sv ====
// 16 colors in flops, all zero after reset; a read in the write cycle returns the old color
`timescale 1ns/10ps

module palette_store (
    input  logic                          clock_in,
    input  logic                          rst_n,
    input  display_cmd_pkg::color_assign_t color_assign,
    input  display_cmd_pkg::pixel_t        pixel_in,
    input  logic                          pixel_in_valid,
    output display_cmd_pkg::pixel_t        pixel_out,
    output logic                          pixel_valid
);

    import display_cmd_pkg::*;

    logic [COLOR_W-1:0] palette [PALETTE_DEPTH];

    always_ff @(posedge clock_in or negedge rst_n) begin
        if (!rst_n) begin
            pixel_valid <= 1'b0;
            for (int i = 0; i < PALETTE_DEPTH; i++) begin
                palette[i] <= '0;
            end
        end else begin
            pixel_valid <= pixel_in_valid;
            if (color_assign.enable) begin
                palette[color_assign.index] <= color_assign.value;
            end
        end
    end

    // Index in, color value out
    always_ff @(posedge clock_in) begin
        if (pixel_in_valid) begin
            pixel_out.x     <= pixel_in.x;
            pixel_out.y     <= pixel_in.y;
            pixel_out.color <= palette[pixel_in.color[INDEX_W-1:0]];
        end
    end

endmodule

// ==== rtl/sprite_pixel_unpacker.sv ====
// 1, 2 or 4 bits per pixel, MSB first; a new byte must not arrive before the last one is done
`timescale 1ns/10ps

module sprite_pixel_unpacker (
    input  logic                          clock_in,
    input  logic                          rst_n,
    input  display_cmd_pkg::sprite_setup_t sprite_setup,
    input  logic                          sprite_enable,
    input  logic                          sprite_data_strobe,
    input  logic [7:0]                    sprite_data,
    output display_cmd_pkg::pixel_t        pixel,
    output logic                          pixel_strobe
);

    import display_cmd_pkg::*;

    logic [7:0]         shift_q;
    logic [3:0]         left_q;
    logic [COORD_W-1:0] column;
    logic [COORD_W-1:0] row;
    logic [COORD_W-1:0] next_column;
    logic [7:0]         source;
    logic [2:0]         bits_per_pixel;
    logic [3:0]         pixels_per_byte;
    logic [INDEX_W-1:0] value;
    logic [INDEX_W-1:0] color_index;
    logic               emit;

    always_comb begin
        if (sprite_setup.total_colors <= 5'd2) begin
            bits_per_pixel  = 3'd1;
            pixels_per_byte = 4'd8;
            value           = {3'b000, source[7]};
        end else if (sprite_setup.total_colors <= 5'd4) begin
            bits_per_pixel  = 3'd2;
            pixels_per_byte = 4'd4;
            value           = {2'b00, source[7:6]};
        end else begin
            bits_per_pixel  = 3'd4;
            pixels_per_byte = 4'd2;
            value           = source[7:4];
        end
    end

    // First pixel comes straight from the incoming byte
    assign source      = sprite_data_strobe ? sprite_data : shift_q;
    assign emit        = sprite_data_strobe || left_q != 4'd0;
    assign color_index = value + sprite_setup.palette_offset;
    assign next_column = column + COORD_W'(1);

    always_ff @(posedge clock_in or negedge rst_n) begin
        if (!rst_n) begin
            left_q       <= '0;
            column       <= '0;
            row          <= '0;
            pixel_strobe <= 1'b0;
        end else begin
            pixel_strobe <= emit;
            if (emit) begin
                left_q <= (sprite_data_strobe ? pixels_per_byte : left_q) - 4'd1;
            end
            if (!sprite_enable) begin
                column <= '0;
                row    <= '0;
            end else if (emit) begin
                // Wrap at the sprite width and move down one row
                if (next_column >= sprite_setup.width) begin
                    column <= '0;
                    row    <= row + COORD_W'(1);
                end else begin
                    column <= next_column;
                end
            end
        end
    end

    always_ff @(posedge clock_in) begin
        if (emit) begin
            shift_q     <= source << bits_per_pixel;
            pixel.x     <= sprite_setup.x + column;
            pixel.y     <= sprite_setup.y + row;
            pixel.color <= {{(COLOR_W-INDEX_W){1'b0}}, color_index};
        end
    end

    // Decoder pacing must leave time to drain each byte
    no_strobe_while_busy: assert property (@(posedge clock_in) disable iff (!rst_n)
        sprite_data_strobe |-> left_q == 4'd0);

endmodule

// ==== rtl/display_cmd_top.sv ====
// Command front end from SPI pins to colored pixels; no back-pressure on the pixel output
`timescale 1ns/10ps

module display_cmd_top (
    input  logic                   clock_in,
    input  logic                   rst_n,
    input  logic                   spi_sck,
    input  logic                   spi_cs_n,
    input  logic                   spi_mosi,
    output display_cmd_pkg::pixel_t pixel_out,
    output logic                   pixel_valid,
    output logic                   clear_buffer,
    output logic                   show_buffer
);

    import display_cmd_pkg::*;

    logic [7:0]    byte_data;
    logic          byte_strobe;
    logic          frame_start;
    logic          frame_active;
    spi_command_t  command;
    color_assign_t color_assign;
    sprite_setup_t sprite_setup;
    logic          sprite_enable;
    logic          sprite_data_strobe;
    logic [7:0]    sprite_data;
    pixel_t        sprite_pixel;
    logic          sprite_pixel_strobe;

    spi_byte_receiver u_receiver (
        .clock_in, .rst_n, .spi_sck, .spi_cs_n, .spi_mosi,
        .byte_data, .byte_strobe, .frame_start, .frame_active
    );

    command_framer u_framer (
        .clock_in, .rst_n, .byte_data, .byte_strobe, .frame_start, .frame_active, .command
    );

    command_decoder u_decoder (
        .clock_in, .rst_n, .command, .color_assign, .sprite_setup, .sprite_enable,
        .sprite_data_strobe, .sprite_data, .clear_buffer, .show_buffer
    );

    sprite_pixel_unpacker u_unpacker (
        .clock_in, .rst_n, .sprite_setup, .sprite_enable, .sprite_data_strobe, .sprite_data,
        .pixel(sprite_pixel), .pixel_strobe(sprite_pixel_strobe)
    );

    palette_store u_palette (
        .clock_in, .rst_n, .color_assign,
        .pixel_in(sprite_pixel), .pixel_in_valid(sprite_pixel_strobe),
        .pixel_out, .pixel_valid
    );

endmodule

// ==== tb/display_cmd_tb.sv ====
// Random SPI traffic against a model; sprite widths stay at 16 or less so rows wrap often
`timescale 1ns/10ps

module display_cmd_tb;

    import display_cmd_pkg::*;

    localparam int NUM_ROUNDS  = 10;
    // Upper bound on bytes sent over all frames
    localparam int MAX_BYTES   = 400;
    localparam int CYCLE_LIMIT = MAX_BYTES * 100 + 5000;

    logic   clock_in;
    logic   rst_n;
    logic   spi_sck;
    logic   spi_cs_n;
    logic   spi_mosi;
    pixel_t pixel_out;
    logic   pixel_valid;
    logic   clear_buffer;
    logic   show_buffer;

    logic [31:0]        lfsr_state;
    logic [COLOR_W-1:0] model_palette [PALETTE_DEPTH];
    logic [7:0]         frame_bytes [$];
    pixel_t             expected [$];
    int                 errors;
    int                 pixels_checked;
    int                 cycle_count;

    display_cmd_top DUT (
        .clock_in, .rst_n, .spi_sck, .spi_cs_n, .spi_mosi,
        .pixel_out, .pixel_valid, .clear_buffer, .show_buffer
    );

    initial begin
        clock_in = 1'b0;
        forever #5 clock_in = ~clock_in;
    end

    // Fibonacci LFSR with taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clock_in);
        #1;
    endtask

    // Mode 0 with data set while SCK is low and 80 ns per bit
    task automatic send_byte(input logic [7:0] b);
        for (int i = 7; i >= 0; i--) begin
            spi_sck  = 1'b0;
            spi_mosi = b[i];
            wait_cycles(4);
            spi_sck = 1'b1;
            wait_cycles(4);
        end
    endtask

    task automatic open_frame();
        spi_cs_n = 1'b0;
        wait_cycles(4);
    endtask

    // Last byte must drain before CS rises
    task automatic close_frame();
        spi_sck = 1'b0;
        wait_cycles(16);
        spi_cs_n = 1'b1;
        wait_cycles(4);
    endtask

    task automatic send_frame();
        open_frame();
        foreach (frame_bytes[i]) begin
            send_byte(frame_bytes[i]);
        end
        close_frame();
        frame_bytes.delete();
    endtask

    task automatic flag_frame(input op_code_e op, input logic exp_clear, input logic exp_show);
        open_frame();
        send_byte(8'(op));
        spi_sck = 1'b0;
        wait_cycles(8);
        if (clear_buffer !== exp_clear) begin
            errors++;
            $display("FAILED at %0t: clear_buffer got %b expected %b", $time, clear_buffer,
                     exp_clear);
        end
        if (show_buffer !== exp_show) begin
            errors++;
            $display("FAILED at %0t: show_buffer got %b expected %b", $time, show_buffer,
                     exp_show);
        end
        close_frame();
        wait_cycles(6);
        if (clear_buffer !== 1'b0 || show_buffer !== 1'b0) begin
            errors++;
            $display("FAILED at %0t: clear_buffer/show_buffer got %b/%b expected 0/0", $time,
                     clear_buffer, show_buffer);
        end
    endtask

    task automatic assign_color();
        logic [7:0] ops [4];
        for (int i = 0; i < 4; i++) begin
            ops[i] = 8'(random_bits(8));
        end
        // Index from operand 1, value from the high bits of operands 2 to 4
        model_palette[ops[0][3:0]] = {ops[1][7:4], ops[2][7:5], ops[3][7:5]};
        frame_bytes.push_back(8'(ASSIGN_COLOR));
        for (int i = 0; i < 4; i++) begin
            frame_bytes.push_back(ops[i]);
        end
        send_frame();
    endtask

    task automatic draw_sprite(input logic [4:0] total_colors, input int data_count);
        logic [COORD_W-1:0] x;
        logic [COORD_W-1:0] y;
        logic [COORD_W-1:0] width;
        logic [COORD_W-1:0] column;
        logic [COORD_W-1:0] row;
        logic [INDEX_W-1:0] offset;
        logic [INDEX_W-1:0] value;
        logic [7:0]         data;
        int                 bits;
        pixel_t             p;
        x      = 10'(random_bits(10));
        y      = 10'(random_bits(10));
        width  = 10'(1 + random_bits(4));
        offset = 4'(random_bits(4));
        bits   = (total_colors <= 5'd2) ? 1 : (total_colors <= 5'd4) ? 2 : 4;
        column = '0;
        row    = '0;
        // Unused high bits of each operand carry random filler
        frame_bytes.push_back(8'(DRAW_SPRITE));
        frame_bytes.push_back({6'(random_bits(6)), x[9:8]});
        frame_bytes.push_back(x[7:0]);
        frame_bytes.push_back({6'(random_bits(6)), y[9:8]});
        frame_bytes.push_back(y[7:0]);
        frame_bytes.push_back({6'(random_bits(6)), width[9:8]});
        frame_bytes.push_back(width[7:0]);
        frame_bytes.push_back({3'(random_bits(3)), total_colors});
        frame_bytes.push_back({4'(random_bits(4)), offset});
        for (int b = 0; b < data_count; b++) begin
            data = 8'(random_bits(8));
            frame_bytes.push_back(data);
            for (int k = 0; k < 8 / bits; k++) begin
                value   = 4'((data >> (8 - bits * (k + 1))) & ((1 << bits) - 1));
                p.x     = x + column;
                p.y     = y + row;
                p.color = model_palette[4'(value + offset)];
                expected.push_back(p);
                if (column + COORD_W'(1) >= width) begin
                    column = '0;
                    row    = row + COORD_W'(1);
                end else begin
                    column = column + COORD_W'(1);
                end
            end
        end
        send_frame();
    endtask

    // Frame cut off inside the setup operands
    task automatic abort_sprite();
        int n;
        n = 1 + int'(random_bits(3) % 7);
        frame_bytes.push_back(8'(DRAW_SPRITE));
        for (int i = 0; i < n; i++) begin
            frame_bytes.push_back(8'(random_bits(8)));
        end
        send_frame();
    endtask

    always @(negedge clock_in) begin
        pixel_t exp_pixel;
        if (rst_n && pixel_valid) begin
            if (expected.size() == 0) begin
                errors++;
                $display("Pixel came out at %0t with none expected", $time);
            end else begin
                exp_pixel = expected.pop_front();
                pixels_checked++;
                if (pixel_out.x !== exp_pixel.x) begin
                    errors++;
                    $display("FAILED at %0t: pixel_out.x got %h expected %h", $time,
                             pixel_out.x, exp_pixel.x);
                end
                if (pixel_out.y !== exp_pixel.y) begin
                    errors++;
                    $display("FAILED at %0t: pixel_out.y got %h expected %h", $time,
                             pixel_out.y, exp_pixel.y);
                end
                if (pixel_out.color !== exp_pixel.color) begin
                    errors++;
                    $display("FAILED at %0t: pixel_out.color got %h expected %h", $time,
                             pixel_out.color, exp_pixel.color);
                end
            end
        end
    end

    always @(posedge clock_in) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Run did not finish within %0d cycles, %0d pixels still expected",
                     CYCLE_LIMIT, expected.size());
            $display("RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        logic [4:0] tc;
        errors         = 0;
        pixels_checked = 0;
        lfsr_state     = 32'heec8;
        rst_n          = 1'b0;
        spi_sck        = 1'b0;
        spi_cs_n       = 1'b1;
        spi_mosi       = 1'b0;
        for (int i = 0; i < PALETTE_DEPTH; i++) begin
            model_palette[i] = '0;
        end
        wait_cycles(10);
        rst_n = 1'b1;
        // Idle bus after reset
        for (int i = 0; i < 20; i++) begin
            wait_cycles(1);
            if (pixel_valid !== 1'b0 || clear_buffer !== 1'b0 || show_buffer !== 1'b0) begin
                errors++;
                $display("FAILED at %0t: pixel_valid/clear_buffer/show_buffer got %b%b%b %s",
                         $time, pixel_valid, clear_buffer, show_buffer, "expected 000");
            end
        end
        flag_frame(CLEAR_BUFFER, 1'b1, 1'b0);
        flag_frame(SHOW_BUFFER, 1'b0, 1'b1);
        for (int r = 0; r < NUM_ROUNDS; r++) begin
            repeat (1 + int'(random_bits(2))) assign_color();
            if (r == 3 || r == 6) begin
                abort_sprite();
            end
            // First rounds cover 1, 2 and 4 bits per pixel
            if (r < 3) begin
                tc = (r == 0) ? 5'd2 : (r == 1) ? 5'd4 : 5'd16;
            end else begin
                tc = 5'(random_bits(5));
            end
            draw_sprite(tc, 1 + int'(random_bits(2)));
        end
        while (expected.size() != 0) begin
            wait_cycles(1);
        end
        wait_cycles(20);
        $display("Done: %0d pixels checked, %0d errors", pixels_checked, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
common/display_cmd_pkg.sv
spi/spi_byte_receiver.sv
spi/command_framer.sv
rtl/command_decoder.sv
rtl/palette_store.sv
rtl/sprite_pixel_unpacker.sv
rtl/display_cmd_top.sv
tb/display_cmd_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log for the fail message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module display_cmd_tb \
    -Mdir obj_dir -o display_cmd_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/display_cmd_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "RESULT: FAIL" sim.log; then
    exit 1
fi
exit 0
